//--- common/uno_pkg.sv
`default_nettype none

package uno_pkg;

    typedef logic [5:0]  card_t;  // {color, value}
    typedef logic [1:0]  color_t; // 0 red, 1 yellow, 2 green, 3 blue
    typedef logic [3:0]  value_t;
    typedef logic [5:0]  idx_t;   // slot index, == count means no card
    typedef logic [10:0] score_t;

    localparam int     HAND_MAX   = 32;
    localparam int     SLOT_W     = $clog2(HAND_MAX);
    localparam int     NUM_COLORS = 4;
    localparam int     INIT_DRAW  = 7;

    localparam value_t VAL_ACTION    = 4'd10; // 10..12 are action cards
    localparam value_t VAL_WILD      = 4'd13;
    localparam value_t VAL_WILD_FOUR = 4'd14;
    localparam card_t  EMPTY_CARD    = 6'h3f;

    localparam score_t PTS_ACTION = 11'd20;
    localparam score_t PTS_WILD   = 11'd50;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_DRAW,       // draw run, req high
        ST_DRAW_REL,   // wait for ack to drop
        ST_PLAY,
        ST_COLOR,      // wild picked, choosing color
        ST_PLAY_REQ,
        ST_PLAY_REL,
        ST_NOCARD,     // single draw that ends the turn
        ST_NOCARD_REL
    } turn_state_t;

    function automatic color_t card_color(input card_t card);
        return card[5:4];
    endfunction

    function automatic value_t card_value(input card_t card);
        return card[3:0];
    endfunction

    function automatic logic is_wild(input card_t card);
        return (card_value(card) == VAL_WILD) || (card_value(card) == VAL_WILD_FOUR);
    endfunction

    function automatic score_t card_points(input card_t card);
        if (is_wild(card)) begin
            return PTS_WILD;
        end
        if (card_value(card) >= VAL_ACTION) begin
            return PTS_ACTION;
        end
        return score_t'(card_value(card));
    endfunction

endpackage

`default_nettype wire

//--- common/hand_if.sv
`timescale 1ns/1ps
`default_nettype none

interface hand_if (
    input logic i_clk,
    input logic i_rst_n
);

    logic           add_en;   // one-cycle pulse
    uno_pkg::card_t add_card;
    logic           rm_en;    // one-cycle pulse, never with add_en
    uno_pkg::idx_t  rm_idx;
    uno_pkg::idx_t  rd_idx;
    uno_pkg::card_t rd_card;  // comb read of rd_idx
    uno_pkg::idx_t  count;

    modport ctrl (
        input  i_clk, i_rst_n, rd_card, count,
        output add_en, add_card, rm_en, rm_idx, rd_idx
    );

    modport store (
        input  i_clk, i_rst_n, add_en, add_card, rm_en, rm_idx, rd_idx,
        output rd_card, count
    );

endinterface

`default_nettype wire

//--- player/hand_store.sv
`timescale 1ns/1ps
`default_nettype none

module hand_store (
    input  logic            i_clk,
    input  logic            i_rst_n,
    hand_if.store           hand,
    input  uno_pkg::idx_t   i_peek_idx,
    output uno_pkg::card_t  o_peek_card,
    output uno_pkg::score_t o_score
);

    uno_pkg::card_t  slots [uno_pkg::HAND_MAX];
    uno_pkg::idx_t   count_q;
    uno_pkg::score_t score_q;
    uno_pkg::card_t  rm_card;
    logic            full;
    logic            do_add;
    logic            do_rm;

    // slots at or past count read as empty
    function automatic uno_pkg::card_t read_slot(input uno_pkg::idx_t idx);
        if (idx < count_q) begin
            return slots[idx[uno_pkg::SLOT_W-1:0]];
        end
        return uno_pkg::EMPTY_CARD;
    endfunction

    assign full   = (count_q == uno_pkg::idx_t'(uno_pkg::HAND_MAX));
    assign do_add = hand.add_en && !full;             // full hand drops the card
    assign do_rm  = hand.rm_en && (hand.rm_idx < count_q);

    always_comb begin
        hand.rd_card = read_slot(hand.rd_idx);
        o_peek_card  = read_slot(i_peek_idx);
        rm_card      = read_slot(hand.rm_idx);
    end

    always_ff @(posedge i_clk) begin
        if (do_add) begin
            slots[count_q[uno_pkg::SLOT_W-1:0]] <= hand.add_card;
        end else if (do_rm) begin
            // close the gap, keeping arrival order
            for (int i = 0; i < uno_pkg::HAND_MAX - 1; i++) begin
                if (i >= hand.rm_idx) begin
                    slots[i] <= slots[i+1];
                end
            end
            slots[uno_pkg::HAND_MAX-1] <= uno_pkg::EMPTY_CARD;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            count_q <= '0;
            score_q <= '0;
        end else if (do_add) begin
            count_q <= count_q + 1'b1;
            score_q <= score_q + uno_pkg::card_points(hand.add_card);
        end else if (do_rm) begin
            count_q <= count_q - 1'b1;
            score_q <= score_q - uno_pkg::card_points(rm_card);
        end
    end

    assign hand.count = count_q;
    assign o_score    = score_q;

endmodule

`default_nettype wire

//--- player/hand_cursor.sv
`timescale 1ns/1ps
`default_nettype none

module hand_cursor (
    input  logic          i_clk,
    input  logic          i_rst_n,
    input  logic          i_left,
    input  logic          i_right,
    input  logic          i_color_mode,
    input  uno_pkg::idx_t i_count,
    output uno_pkg::idx_t o_index
);

    typedef enum logic [1:0] {
        CUR_STAY,
        CUR_LEFT,   // left held, wait for release
        CUR_RIGHT
    } cur_state_t;

    cur_state_t    state_q;
    cur_state_t    state_d;
    uno_pkg::idx_t index_q;
    uno_pkg::idx_t index_d;
    uno_pkg::idx_t limit;
    logic          mode_q;
    logic          step_left;
    logic          step_right;

    // top slot: no-card slot in hand mode, last color otherwise
    assign limit = i_color_mode ? uno_pkg::idx_t'(uno_pkg::NUM_COLORS - 1) : i_count;

    assign step_left  = (state_q == CUR_STAY) && i_left;
    assign step_right = (state_q == CUR_STAY) && !i_left && i_right;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CUR_STAY: begin
                if (i_left) begin
                    state_d = CUR_LEFT;
                end else if (i_right) begin
                    state_d = CUR_RIGHT;
                end
            end
            CUR_LEFT:  if (!i_left) state_d = CUR_STAY;
            CUR_RIGHT: if (!i_right) state_d = CUR_STAY;
            default:   state_d = CUR_STAY;
        endcase

        if (i_color_mode != mode_q) begin
            index_d = '0;
        end else if (step_left) begin
            index_d = (index_q == '0) ? limit : index_q - 1'b1;
        end else if (step_right) begin
            index_d = (index_q >= limit) ? '0 : index_q + 1'b1;
        end else if (index_q > limit) begin
            index_d = limit; // hand shrank under the cursor
        end else begin
            index_d = index_q;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= CUR_STAY;
            index_q <= '0;
            mode_q  <= 1'b0;
        end else begin
            state_q <= state_d;
            index_q <= index_d;
            mode_q  <= i_color_mode;
        end
    end

    assign o_index = index_q;

endmodule

`default_nettype wire

//--- player/turn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module turn_ctrl (
    input  logic           i_clk,
    input  logic           i_rst_n,
    input  logic           i_init,
    input  logic           i_start,
    input  logic           i_draw_two,
    input  logic           i_draw_four,
    input  logic           i_select,
    input  uno_pkg::card_t i_prev_card,
    input  uno_pkg::idx_t  i_cursor,
    output logic           o_color_mode,
    hand_if.ctrl           hand,
    output logic           o_draw_req,
    input  logic           i_draw_ack,
    input  uno_pkg::card_t i_drawn_card,
    output logic           o_play_req,
    input  logic           i_play_ack,
    output uno_pkg::card_t o_play_card
);

    uno_pkg::turn_state_t state_q;
    uno_pkg::turn_state_t state_d;
    logic [2:0]           draws_q;     // cards left in this draw run
    logic [2:0]           draws_d;
    logic                 sel_q;
    logic                 sel_rise;
    logic                 legal;
    logic                 play_load;
    uno_pkg::idx_t        wild_idx_q;
    uno_pkg::idx_t        sel_idx;
    uno_pkg::card_t       play_card_q;
    uno_pkg::card_t       play_card_d;

    assign sel_rise = i_select & ~sel_q;

    // in color mode the cursor names a color, so address the stored wild instead
    assign sel_idx = (state_q == uno_pkg::ST_COLOR) ? wild_idx_q : i_cursor;

    assign legal = (uno_pkg::card_color(hand.rd_card) == uno_pkg::card_color(i_prev_card)) ||
                   (uno_pkg::card_value(hand.rd_card) == uno_pkg::card_value(i_prev_card));

    assign play_card_d = (state_q == uno_pkg::ST_COLOR) ?
                         {uno_pkg::color_t'(i_cursor), uno_pkg::card_value(hand.rd_card)} :
                         hand.rd_card;

    assign o_draw_req   = (state_q == uno_pkg::ST_DRAW) || (state_q == uno_pkg::ST_NOCARD);
    assign o_play_req   = (state_q == uno_pkg::ST_PLAY_REQ);
    assign o_color_mode = (state_q == uno_pkg::ST_COLOR);
    assign o_play_card  = play_card_q;

    assign hand.add_en   = o_draw_req & i_draw_ack; // card captured with the ack
    assign hand.add_card = i_drawn_card;
    assign hand.rd_idx   = sel_idx;
    assign hand.rm_idx   = sel_idx;

    always_comb begin
        state_d    = state_q;
        draws_d    = draws_q;
        hand.rm_en = 1'b0;
        play_load  = 1'b0;
        case (state_q)
            uno_pkg::ST_IDLE: begin
                if (i_start) begin
                    if (i_draw_two) begin
                        draws_d = 3'd2;
                        state_d = uno_pkg::ST_DRAW;
                    end else if (i_draw_four) begin
                        draws_d = 3'd4;
                        state_d = uno_pkg::ST_DRAW;
                    end else begin
                        state_d = uno_pkg::ST_PLAY;
                    end
                end else if (i_init) begin
                    draws_d = 3'(uno_pkg::INIT_DRAW);
                    state_d = uno_pkg::ST_DRAW;
                end
            end
            uno_pkg::ST_DRAW: begin
                if (i_draw_ack) begin
                    draws_d = draws_q - 3'd1;
                    state_d = uno_pkg::ST_DRAW_REL;
                end
            end
            uno_pkg::ST_DRAW_REL: begin
                if (!i_draw_ack) begin
                    if (draws_q != 3'd0) begin
                        state_d = uno_pkg::ST_DRAW;
                    end else if (i_start) begin
                        state_d = uno_pkg::ST_PLAY;
                    end else begin
                        state_d = uno_pkg::ST_IDLE;
                    end
                end
            end
            uno_pkg::ST_PLAY: begin
                if (sel_rise) begin
                    if (i_cursor >= hand.count) begin
                        state_d = uno_pkg::ST_NOCARD;
                    end else if (uno_pkg::is_wild(hand.rd_card)) begin
                        state_d = uno_pkg::ST_COLOR;
                    end else if (legal) begin
                        hand.rm_en = 1'b1;
                        play_load  = 1'b1;
                        state_d    = uno_pkg::ST_PLAY_REQ;
                    end
                end
            end
            uno_pkg::ST_COLOR: begin
                if (sel_rise) begin
                    hand.rm_en = 1'b1;
                    play_load  = 1'b1;
                    state_d    = uno_pkg::ST_PLAY_REQ;
                end
            end
            uno_pkg::ST_PLAY_REQ: begin
                if (i_play_ack) begin
                    state_d = uno_pkg::ST_PLAY_REL;
                end
            end
            uno_pkg::ST_PLAY_REL: begin
                if (!i_play_ack) begin
                    state_d = uno_pkg::ST_IDLE;
                end
            end
            uno_pkg::ST_NOCARD: begin
                if (i_draw_ack) begin
                    state_d = uno_pkg::ST_NOCARD_REL;
                end
            end
            uno_pkg::ST_NOCARD_REL: begin
                if (!i_draw_ack) begin
                    state_d = uno_pkg::ST_IDLE;
                end
            end
            default: state_d = uno_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= uno_pkg::ST_IDLE;
            draws_q <= 3'd0;
            sel_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            draws_q <= draws_d;
            sel_q   <= i_select;
        end
    end

    always_ff @(posedge i_clk) begin
        if (play_load) begin
            play_card_q <= play_card_d; // held until the ack
        end
        if (state_q == uno_pkg::ST_PLAY) begin
            wild_idx_q <= i_cursor;
        end
    end

endmodule

`default_nettype wire

//--- player/uno_player.sv
`timescale 1ns/1ps
`default_nettype none

module uno_player (
    input  logic            i_clk,
    input  logic            i_rst_n,
    input  logic            i_init,
    input  logic            i_start,
    input  logic            i_draw_two,
    input  logic            i_draw_four,
    input  logic            i_left,
    input  logic            i_right,
    input  logic            i_select,
    input  uno_pkg::card_t  i_prev_card,
    output logic            o_draw_req,
    input  logic            i_draw_ack,
    input  uno_pkg::card_t  i_drawn_card,
    output logic            o_play_req,
    input  logic            i_play_ack,
    output uno_pkg::card_t  o_play_card,
    output uno_pkg::idx_t   o_index,
    output uno_pkg::idx_t   o_hand_num,
    output uno_pkg::score_t o_score,
    input  uno_pkg::idx_t   i_peek_idx,
    output uno_pkg::card_t  o_peek_card
);

    logic          color_mode;
    uno_pkg::idx_t cursor;

    hand_if u_hand_if (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n)
    );

    // select is held off while a cursor button is down
    turn_ctrl u_turn_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_init       (i_init),
        .i_start      (i_start),
        .i_draw_two   (i_draw_two),
        .i_draw_four  (i_draw_four),
        .i_select     (i_select & ~i_left & ~i_right),
        .i_prev_card  (i_prev_card),
        .i_cursor     (cursor),
        .o_color_mode (color_mode),
        .hand         (u_hand_if.ctrl),
        .o_draw_req   (o_draw_req),
        .i_draw_ack   (i_draw_ack),
        .i_drawn_card (i_drawn_card),
        .o_play_req   (o_play_req),
        .i_play_ack   (i_play_ack),
        .o_play_card  (o_play_card)
    );

    hand_store u_hand_store (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .hand        (u_hand_if.store),
        .i_peek_idx  (i_peek_idx),
        .o_peek_card (o_peek_card),
        .o_score     (o_score)
    );

    hand_cursor u_hand_cursor (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_left       (i_left),
        .i_right      (i_right),
        .i_color_mode (color_mode),
        .i_count      (u_hand_if.count),
        .o_index      (cursor)
    );

    assign o_index    = cursor;
    assign o_hand_num = u_hand_if.count;

endmodule

`default_nettype wire

//--- test/uno_player_assert.sv
`timescale 1ns/1ps
`default_nettype none

module uno_player_assert (
    input logic           i_clk,
    input logic           i_rst_n,
    input logic           o_draw_req,
    input logic           i_draw_ack,
    input logic           o_play_req,
    input logic           i_play_ack,
    input uno_pkg::card_t o_play_card,
    input uno_pkg::idx_t  o_hand_num
);

    draw_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_draw_req && !i_draw_ack |=> o_draw_req)
        else $error("o_draw_req fell before i_draw_ack");

    play_req_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_play_req && !i_play_ack |=> o_play_req)
        else $error("o_play_req fell before i_play_ack");

    // card must not move while the request is up
    play_card_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_play_req && $past(o_play_req) |-> $stable(o_play_card))
        else $error("o_play_card changed during a play request");

    one_request: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(o_draw_req && o_play_req))
        else $error("draw and play requests high together");

    hand_size: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_hand_num <= uno_pkg::idx_t'(uno_pkg::HAND_MAX))
        else $error("o_hand_num above hand capacity");

endmodule

bind uno_player uno_player_assert u_assert (.*);

`default_nettype wire

//--- test/tb_uno_player.sv
`timescale 1ns/1ps
`default_nettype none

module tb_uno_player;

    localparam int HS_CYCLES       = 200;
    localparam int WATCHDOG_CYCLES = 38 * HS_CYCLES + 1000; // 38 handshakes in all tests

    logic            i_clk = 1'b0;
    logic            i_rst_n, i_init, i_start, i_draw_two, i_draw_four;
    logic            i_left, i_right, i_select, i_draw_ack, i_play_ack;
    logic            o_draw_req, o_play_req;
    uno_pkg::card_t  i_prev_card, i_drawn_card, o_play_card, o_peek_card;
    uno_pkg::idx_t   o_index, o_hand_num, i_peek_idx;
    uno_pkg::score_t o_score;
    uno_pkg::card_t  deck[$];     // next cards handed out on draws
    uno_pkg::card_t  exp_hand[$];
    uno_pkg::card_t  played[$];
    int              exp_score  = 0;
    int              draws_seen = 0;
    int              plays_seen = 0;
    int              ack_wait   = 0;

    uno_player u_dut (.*);

    always #20 i_clk = ~i_clk;

    task automatic abort_run(input string why);
        $display("%s at %0t ns", why, $time);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "check failed");
        end
    endtask

    function automatic int points_of(input uno_pkg::card_t card);
        if (card[3:0] == uno_pkg::VAL_WILD || card[3:0] == uno_pkg::VAL_WILD_FOUR) begin
            return 50;
        end
        return (card[3:0] >= 4'd10) ? 20 : int'(card[3:0]);
    endfunction

    function automatic uno_pkg::card_t random_card(input bit wild);
        uno_pkg::value_t value;
        value = wild ? uno_pkg::value_t'(13 + $urandom % 2) : uno_pkg::value_t'($urandom % 13);
        return {uno_pkg::color_t'($urandom % 4), value};
    endfunction

    // draw and play servers hold off a random few cycles before each ack
    always @(negedge i_clk) begin
        if ((o_draw_req && !i_draw_ack) || (o_play_req && !i_play_ack)) begin
            if (ack_wait > 0) begin
                ack_wait--;
            end else if (o_play_req) begin
                played.push_back(o_play_card);
                plays_seen++;
                i_play_ack = 1'b1;
                ack_wait = $urandom % 4;
            end else begin
                if (deck.size() == 0) abort_run("draw request with no card prepared");
                i_drawn_card = deck.pop_front();
                if (exp_hand.size() < uno_pkg::HAND_MAX) begin
                    exp_hand.push_back(i_drawn_card);
                    exp_score += points_of(i_drawn_card);
                end
                draws_seen++;
                i_draw_ack = 1'b1;
                ack_wait = $urandom % 4;
            end
        end else begin
            if (!o_draw_req) i_draw_ack = 1'b0;
            if (!o_play_req) i_play_ack = 1'b0;
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge i_clk);
        abort_run("watchdog expired before the tests finished");
    end

    task automatic wait_handshakes(input bit play, input int base, input int n);
        int cycles;
        cycles = 0;
        do begin
            @(posedge i_clk);
            cycles++;
            if (cycles > n * HS_CYCLES) abort_run("timed out waiting for a handshake");
        end while ((play ? plays_seen : draws_seen) < base + n || i_draw_ack || i_play_ack);
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) begin
            @(negedge i_clk);
            check_val("o_play_req", o_play_req, 0);
            check_val("o_draw_req", o_draw_req, 0);
        end
    endtask

    task automatic check_hand();
        @(negedge i_clk);
        check_val("o_hand_num", o_hand_num, exp_hand.size());
        check_val("o_score", o_score, exp_score);
        for (int i = 0; i <= exp_hand.size(); i++) begin
            @(negedge i_clk);
            i_peek_idx = uno_pkg::idx_t'(i);
            #1;
            check_val($sformatf("o_peek_card[%0d]", i), o_peek_card,
                      (i < exp_hand.size()) ? exp_hand[i] : uno_pkg::EMPTY_CARD);
        end
    endtask

    task automatic press(input bit right, input int hold);
        @(negedge i_clk);
        i_left = !right;
        i_right = right;
        repeat (hold) @(negedge i_clk);
        i_left = 1'b0;
        i_right = 1'b0;
        repeat (2) @(negedge i_clk);
    endtask

    task automatic press_select();
        @(negedge i_clk);
        i_select = 1'b1;
        @(negedge i_clk);
        i_select = 1'b0;
    endtask

    task automatic move_to(input int slot);
        @(negedge i_clk);
        repeat (uno_pkg::HAND_MAX + 2) begin
            if (o_index != slot) press(1'b1, 1);
        end
        check_val("o_index", o_index, slot);
    endtask

    // start held until the penalty draws are done
    task automatic start_turn(input int draws);
        int base;
        base = draws_seen;
        @(negedge i_clk);
        i_start = 1'b1;
        i_draw_two = (draws == 2);
        i_draw_four = (draws == 4);
        if (draws > 0) wait_handshakes(1'b0, base, draws);
        @(negedge i_clk);
        i_start = 1'b0;
        i_draw_two = 1'b0;
        i_draw_four = 1'b0;
        expect_quiet(20);
        check_val("draw count", draws_seen - base, draws);
    endtask

    task automatic expect_play(input int slot, input uno_pkg::card_t card);
        int base;
        base = plays_seen;
        press_select();
        wait_handshakes(1'b1, base, 1);
        check_val("o_play_card", played[$], card);
        exp_score -= points_of(exp_hand[slot]);
        exp_hand.delete(slot);
        check_hand();
    endtask

    task automatic test_reset();
        check_val("o_draw_req", o_draw_req, 0);
        check_val("o_play_req", o_play_req, 0);
        check_val("o_index", o_index, 0);
        check_hand();
    endtask

    task automatic test_init_draw();
        repeat (7) deck.push_back(random_card(1'b0));
        @(negedge i_clk);
        i_init = 1'b1;
        @(negedge i_clk);
        i_init = 1'b0;
        wait_handshakes(1'b0, 0, 7);
        expect_quiet(20);
        check_val("draw count", draws_seen, 7);
        check_hand();
    endtask

    task automatic test_cursor();
        press(1'b0, 1);
        check_val("o_index", o_index, exp_hand.size()); // wraps to no-card slot
        press(1'b1, 1);
        check_val("o_index", o_index, 0);
        press(1'b1, 5);
        check_val("o_index", o_index, 1);
        press(1'b1, 1);
        check_val("o_index", o_index, 2);
    endtask

    task automatic test_legal_play();
        uno_pkg::card_t bad;
        uno_pkg::card_t good;
        bad = exp_hand[1];
        good = exp_hand[2];
        i_prev_card = {bad[5:4] + 2'd1, uno_pkg::value_t'((bad[3:0] + 1) % 13)};
        start_turn(0);
        move_to(1);
        press_select();
        expect_quiet(50); // illegal card is ignored
        i_prev_card = {good[5:4], uno_pkg::value_t'((good[3:0] + 1) % 13)};
        move_to(2);
        expect_play(2, good);
    endtask

    task automatic test_wild_play();
        uno_pkg::card_t wild;
        repeat (3) deck.push_back(random_card(1'b0));
        wild = random_card(1'b1);
        deck.push_back(wild);
        start_turn(4);
        check_hand();
        move_to(exp_hand.size() - 1);
        press_select();
        expect_quiet(2);
        check_val("o_index", o_index, 0); // color mode restarts the cursor
        press(1'b1, 1);
        press(1'b1, 1);
        check_val("o_index", o_index, 2);
        expect_play(exp_hand.size() - 1, {2'd2, wild[3:0]});
    endtask

    task automatic test_draw_two_no_card();
        int num0;
        int base;
        num0 = exp_hand.size();
        repeat (2) deck.push_back(random_card($urandom % 2 == 0));
        start_turn(2);
        move_to(exp_hand.size());
        deck.push_back(random_card(1'b0));
        base = draws_seen;
        press_select();
        wait_handshakes(1'b0, base, 1);
        expect_quiet(50);
        check_val("o_hand_num", o_hand_num, num0 + 3);
        check_hand();
    endtask

    // three opening draws overflow the hand
    task automatic test_full_hand();
        uno_pkg::card_t first;
        int             base;
        for (int run = 0; run < 3; run++) begin
            repeat (7) deck.push_back(random_card(1'b0));
            base = draws_seen;
            @(negedge i_clk);
            i_init = 1'b1;
            @(negedge i_clk);
            i_init = 1'b0;
            wait_handshakes(1'b0, base, 7);
            expect_quiet(20);
            check_val("draw count", draws_seen - base, 7);
        end
        check_val("o_hand_num", o_hand_num, uno_pkg::HAND_MAX);
        check_hand();
        first = exp_hand[0];
        @(negedge i_clk);
        i_prev_card = {first[5:4] + 2'd1, first[3:0]}; // legal by value only
        start_turn(0);
        move_to(0);
        expect_play(0, first);
    endtask

    initial begin
        void'($urandom(32'hf51));
        i_rst_n = 1'b0;
        i_init = 1'b0;
        i_start = 1'b0;
        i_draw_two = 1'b0;
        i_draw_four = 1'b0;
        i_left = 1'b0;
        i_right = 1'b0;
        i_select = 1'b0;
        i_draw_ack = 1'b0;
        i_play_ack = 1'b0;
        i_prev_card = '0;
        i_drawn_card = '0;
        i_peek_idx = '0;
        repeat (16) @(negedge i_clk);
        i_rst_n = 1'b1;
        test_reset();
        test_init_draw();
        test_cursor();
        test_legal_play();
        test_wild_play();
        test_draw_two_no_card();
        test_full_hand();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/uno_pkg.sv
common/hand_if.sv
player/hand_store.sv
player/hand_cursor.sv
player/turn_ctrl.sv
player/uno_player.sv
test/uno_player_assert.sv
test/tb_uno_player.sv
